//--- rtl/vcr_arch_pkg.sv
/*
  Router geometry shared by every block of the VC router: port count,
  VC count, index widths and the port names used as port indexes.
  Referenced through scoped names only.
*/

package vcr_arch_pkg;

  // four mesh directions, each one link in and one link out
  localparam int NumPorts = 4;

  // virtual channels per physical link
  localparam int NumVc = 2;

  // index widths, kept in step with the counts above
  localparam int VcIdWidth = 1;
  localparam int PortIdWidth = 2;

  // port names double as crossbar indexes
  typedef enum logic [PortIdWidth-1:0] {
    North = 2'd0,
    East  = 2'd1,
    South = 2'd2,
    West  = 2'd3
  } port_e;

endpackage

//--- rtl/vcr_flit_pkg.sv
/*
  Flit format of the VC router. Every flit is a whole packet: a header
  naming its VC, destination and source port, followed by the payload.
*/

package vcr_flit_pkg;

  localparam int PayloadWidth = 11;

  // vc is rewritten at every hop, dst selects the output directly
  typedef struct packed {
    logic [vcr_arch_pkg::VcIdWidth-1:0] vc;
    vcr_arch_pkg::port_e                dst;
    vcr_arch_pkg::port_e                src;
  } flit_hdr_t;

  // header sits in the upper bits
  typedef struct packed {
    flit_hdr_t                 hdr;
    logic [PayloadWidth-1:0]   payload;
  } flit_t;

endpackage

//--- rtl/vcr_req_if.sv
/*
  Head request path between one input port and the switch allocator.
  The input port shows its VC heads, the allocator answers with a grant
  that pops the named VC at the next clock edge.
*/

`timescale 1ns/1ps

interface vcr_req_if;

  logic [vcr_arch_pkg::NumVc-1:0]                       head_v;
  vcr_arch_pkg::port_e [vcr_arch_pkg::NumVc-1:0]        head_dst;
  logic                                                 grant_v;
  logic [vcr_arch_pkg::VcIdWidth-1:0]                   grant_vc;

  modport input_port (output head_v, head_dst, input grant_v, grant_vc);

  modport allocator (input head_v, head_dst, output grant_v, grant_vc);

endinterface

//--- rtl/vcr_input_port.sv
/*
  One router input: a small FIFO per VC, filled from the upstream link and
  drained by allocator grants. Each pop returns one credit upstream and
  hands the popped flit, registered, to the switch traversal stage.
*/

`timescale 1ns/1ps

module vcr_input_port #(
  parameter int VcDepth = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 data_v_i,
  input  vcr_flit_pkg::flit_t                  data_i,
  output logic                                 credit_v_o,
  output logic [vcr_arch_pkg::VcIdWidth-1:0]   credit_id_o,
  vcr_req_if.input_port                        req,
  output vcr_flit_pkg::flit_t                  pop_flit_o
);

  localparam int PtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntWidth = $clog2(VcDepth + 1);

  vcr_flit_pkg::flit_t                 mem    [vcr_arch_pkg::NumVc][VcDepth];
  logic [PtrWidth-1:0]                 wr_ptr [vcr_arch_pkg::NumVc];
  logic [PtrWidth-1:0]                 rd_ptr [vcr_arch_pkg::NumVc];
  logic [CntWidth-1:0]                 count  [vcr_arch_pkg::NumVc];
  logic [vcr_arch_pkg::NumVc-1:0]      push;
  logic [vcr_arch_pkg::NumVc-1:0]      pop;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(VcDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // the flit's own vc field picks the buffer
  always_comb begin
    for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
      push[v] = data_v_i && (data_i.hdr.vc == v);
      pop[v]  = req.grant_v && (req.grant_vc == v);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        count[v]  <= '0;
      end
    end else begin
      for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
        if (push[v]) begin
          wr_ptr[v] <= next_ptr(wr_ptr[v]);
        end
        if (pop[v]) begin
          rd_ptr[v] <= next_ptr(rd_ptr[v]);
        end
        // push and pop may hit the same vc in one cycle
        count[v] <= count[v] + CntWidth'(push[v]) - CntWidth'(pop[v]);
      end
    end
  end

  // storage and the flit handed to the crossbar
  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem[data_i.hdr.vc][wr_ptr[data_i.hdr.vc]] <= data_i;
    end
    if (req.grant_v) begin
      pop_flit_o <= mem[req.grant_vc][rd_ptr[req.grant_vc]];
    end
  end

  // one credit per popped flit, a cycle after the pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= req.grant_v;
      credit_id_o <= req.grant_vc;
    end
  end

  always_comb begin
    for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
      req.head_v[v]   = (count[v] != '0);
      req.head_dst[v] = mem[v][rd_ptr[v]].hdr.dst;
    end
  end

endmodule

//--- rtl/vcr_switch_alloc.sv
/*
  Two-step separable switch allocator. A local round-robin picks one VC
  per input, a global round-robin picks one input per output among those
  whose pick targets it. Fully combinational apart from the pointers.
*/

`timescale 1ns/1ps

module vcr_switch_alloc (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  vcr_req_if.allocator                                     req [vcr_arch_pkg::NumPorts],
  input  logic [vcr_arch_pkg::NumPorts-1:0]                vc_free_v_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] vc_sel_i,
  output logic [vcr_arch_pkg::NumPorts-1:0]                send_v_o,
  output logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::NumPorts-1:0] send_in_o,
  output logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] send_vc_o
);

  logic [vcr_arch_pkg::NumVc-1:0]                           head_v   [vcr_arch_pkg::NumPorts];
  vcr_arch_pkg::port_e [vcr_arch_pkg::NumVc-1:0]            head_dst [vcr_arch_pkg::NumPorts];
  logic [vcr_arch_pkg::NumPorts-1:0]                        local_v;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]   local_vc;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]   local_ptr;
  vcr_arch_pkg::port_e [vcr_arch_pkg::NumPorts-1:0]         local_dst;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::PortIdWidth-1:0] global_ptr;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::PortIdWidth-1:0] global_win;
  logic [vcr_arch_pkg::NumPorts-1:0]                        in_grant;

  // round-robin pick over the first n requests, ptr holds top priority
  // shared by both steps, vc requests are zero-extended to port width
  function automatic logic [vcr_arch_pkg::PortIdWidth-1:0] rr_pick(
    input logic [vcr_arch_pkg::NumPorts-1:0]    req_vec,
    input logic [vcr_arch_pkg::PortIdWidth-1:0] ptr,
    input int                                   n
  );
    logic [vcr_arch_pkg::PortIdWidth-1:0] pick;
    int idx;
    pick = ptr;
    for (int i = n - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % n;
      if (req_vec[idx]) begin
        pick = vcr_arch_pkg::PortIdWidth'(idx);
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < vcr_arch_pkg::NumPorts; p++) begin : gen_req
    assign head_v[p]       = req[p].head_v;
    assign head_dst[p]     = req[p].head_dst;
    assign req[p].grant_v  = in_grant[p];
    assign req[p].grant_vc = local_vc[p];
  end

  // ================================================
  // local step, one vc per input
  // ================================================
  always_comb begin
    for (int p = 0; p < vcr_arch_pkg::NumPorts; p++) begin
      local_v[p]   = |head_v[p];
      local_vc[p]  = vcr_arch_pkg::VcIdWidth'(rr_pick(vcr_arch_pkg::NumPorts'(head_v[p]),
                       vcr_arch_pkg::PortIdWidth'(local_ptr[p]), vcr_arch_pkg::NumVc));
      local_dst[p] = head_dst[p][local_vc[p]];
    end
  end

  // ================================================
  // global step, one input per output
  // ================================================
  always_comb begin
    logic [vcr_arch_pkg::NumPorts-1:0] cand;
    in_grant = '0;
    for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
      for (int i = 0; i < vcr_arch_pkg::NumPorts; i++) begin
        cand[i] = local_v[i] && (local_dst[i] == vcr_arch_pkg::port_e'(o));
      end
      global_win[o] = rr_pick(cand, global_ptr[o], vcr_arch_pkg::NumPorts);
      // an output without downstream space grants nothing
      send_v_o[o]   = (|cand) && vc_free_v_i[o];
      send_in_o[o]  = send_v_o[o] ? (vcr_arch_pkg::NumPorts'(1) << global_win[o]) : '0;
      send_vc_o[o]  = vc_sel_i[o];
      in_grant      = in_grant | send_in_o[o];
    end
  end

  // pointers move past the winner only when it is granted
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      local_ptr  <= '0;
      global_ptr <= '0;
    end else begin
      for (int p = 0; p < vcr_arch_pkg::NumPorts; p++) begin
        if (in_grant[p]) begin
          local_ptr[p] <= (local_vc[p] == vcr_arch_pkg::NumVc - 1) ? '0 : local_vc[p] + 1'b1;
        end
      end
      for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
        if (send_v_o[o]) begin
          global_ptr[o] <= (global_win[o] == vcr_arch_pkg::NumPorts - 1) ? '0
                           : global_win[o] + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/vcr_output_credits.sv
/*
  Downstream credit bookkeeping, one counter per output VC. Offers the
  allocator the VC with the most free slots for each output.
*/

`timescale 1ns/1ps

module vcr_output_credits #(
  parameter int VcDepth = 2
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0]                credit_v_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] credit_id_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0]                consume_v_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] consume_vc_i,
  output logic [vcr_arch_pkg::NumPorts-1:0]                vc_free_v_o,
  output logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] vc_sel_o
);

  localparam int CntWidth = $clog2(VcDepth + 1);

  logic [CntWidth-1:0] cnt [vcr_arch_pkg::NumPorts][vcr_arch_pkg::NumVc];

  // counters start full, the downstream buffers are empty
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
        for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
          cnt[o][v] <= CntWidth'(VcDepth);
        end
      end
    end else begin
      for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
        for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
          cnt[o][v] <= cnt[o][v]
                       + CntWidth'(credit_v_i[o] && (credit_id_i[o] == v))
                       - CntWidth'(consume_v_i[o] && (consume_vc_i[o] == v));
        end
      end
    end
  end

  // most credits wins, ties stay with the lower index
  always_comb begin
    for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
      vc_sel_o[o] = '0;
      for (int v = 1; v < vcr_arch_pkg::NumVc; v++) begin
        if (cnt[o][v] > cnt[o][vc_sel_o[o]]) begin
          vc_sel_o[o] = vcr_arch_pkg::VcIdWidth'(v);
        end
      end
      vc_free_v_o[o] = (cnt[o][vc_sel_o[o]] != '0);
    end
  end

endmodule

//--- rtl/vcr_switch_traversal.sv
/*
  Crossbar and output stage. The granted input's popped flit is steered to
  its output, its VC field set to the assigned downstream VC, and the
  result registered onto the output link.
*/

`timescale 1ns/1ps

module vcr_switch_traversal (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0] pop_flit_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0]                send_v_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::NumPorts-1:0] send_in_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] send_vc_i,
  output logic [vcr_arch_pkg::NumPorts-1:0]                data_v_o,
  output vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0] data_o
);

  logic [vcr_arch_pkg::NumPorts-1:0]                                  st_v_q;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::NumPorts-1:0]      st_in_q;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]     st_vc_q;
  vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0]                   xbar_flit;

  // grant info is delayed to line up with the registered popped flit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      st_v_q <= '0;
    end else begin
      st_v_q <= send_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    st_in_q <= send_in_i;
    st_vc_q <= send_vc_i;
  end

  always_comb begin
    for (int o = 0; o < vcr_arch_pkg::NumPorts; o++) begin
      xbar_flit[o] = '0;
      for (int i = 0; i < vcr_arch_pkg::NumPorts; i++) begin
        if (st_in_q[o][i]) begin
          xbar_flit[o] = pop_flit_i[i];
        end
      end
      xbar_flit[o].hdr.vc = st_vc_q[o];
    end
  end

  // output link register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= st_v_q;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= xbar_flit;
  end

endmodule

//--- rtl/vcr_router.sv
/*
  Four-port VC router top level with credit-based links on every side.
  Instantiate with the per-VC buffer depth, upstream and downstream
  neighbours must start with VcDepth credits per VC.
*/

`timescale 1ns/1ps

module vcr_router #(
  parameter int VcDepth = 2
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0]                data_v_i,
  input  vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0] data_i,
  output logic [vcr_arch_pkg::NumPorts-1:0]                credit_v_o,
  output logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] credit_id_o,
  input  logic [vcr_arch_pkg::NumPorts-1:0]                credit_v_i,
  input  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] credit_id_i,
  output logic [vcr_arch_pkg::NumPorts-1:0]                data_v_o,
  output vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0] data_o
);

  vcr_req_if req_if [vcr_arch_pkg::NumPorts] ();

  vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0]                  pop_flit;
  logic [vcr_arch_pkg::NumPorts-1:0]                                 send_v;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::NumPorts-1:0]     send_in;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]    send_vc;
  logic [vcr_arch_pkg::NumPorts-1:0]                                 vc_free_v;
  logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]    vc_sel;

  // ================================================
  // input buffers
  // ================================================
  for (genvar p = 0; p < vcr_arch_pkg::NumPorts; p++) begin : gen_input_port
    vcr_input_port #(
      .VcDepth     (VcDepth)
    ) u_input_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .req         (req_if[p]),
      .pop_flit_o  (pop_flit[p])
    );
  end

  // ================================================
  // allocation, credits and crossbar
  // ================================================
  vcr_switch_alloc u_switch_alloc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req         (req_if),
    .vc_free_v_i (vc_free_v),
    .vc_sel_i    (vc_sel),
    .send_v_o    (send_v),
    .send_in_o   (send_in),
    .send_vc_o   (send_vc)
  );

  vcr_output_credits #(
    .VcDepth      (VcDepth)
  ) u_output_credits (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .credit_v_i   (credit_v_i),
    .credit_id_i  (credit_id_i),
    .consume_v_i  (send_v),
    .consume_vc_i (send_vc),
    .vc_free_v_o  (vc_free_v),
    .vc_sel_o     (vc_sel)
  );

  vcr_switch_traversal u_switch_traversal (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pop_flit_i (pop_flit),
    .send_v_i   (send_v),
    .send_in_i  (send_in),
    .send_vc_i  (send_vc),
    .data_v_o   (data_v_o),
    .data_o     (data_o)
  );

endmodule

//--- tb/vcr_assertions.sv
/*
  Protocol checks bound into the router top level: quiet outputs until
  the first flit, upstream credit return per input VC, and downstream
  credit use per output VC.
*/

`timescale 1ns/1ps

module vcr_assertions #(
  parameter int VcDepth = 2
) (
  input logic                                                             clk_i,
  input logic                                                             rst_n_i,
  input logic [vcr_arch_pkg::NumPorts-1:0]                                in_v_i,
  input vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0]                 in_data_i,
  input logic [vcr_arch_pkg::NumPorts-1:0]                                up_credit_v_i,
  input logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]   up_credit_id_i,
  input logic [vcr_arch_pkg::NumPorts-1:0]                                ds_credit_v_i,
  input logic [vcr_arch_pkg::NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0]   ds_credit_id_i,
  input logic [vcr_arch_pkg::NumPorts-1:0]                                out_v_i,
  input vcr_flit_pkg::flit_t [vcr_arch_pkg::NumPorts-1:0]                 out_data_i
);

  int   fail_count = 0;
  logic started    = 1'b0;
  logic seen_input = 1'b0;
  // accepted flits not yet credited back and downstream credits left
  int   up_open [vcr_arch_pkg::NumPorts][vcr_arch_pkg::NumVc];
  int   ds_cred [vcr_arch_pkg::NumPorts][vcr_arch_pkg::NumVc];

  always_ff @(posedge clk_i) begin
    started <= 1'b1;
    if (rst_n_i && |in_v_i) begin
      seen_input <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < vcr_arch_pkg::NumPorts; p++) begin
        for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
          up_open[p][v] <= 0;
          ds_cred[p][v] <= VcDepth;
        end
      end
    end else begin
      for (int p = 0; p < vcr_arch_pkg::NumPorts; p++) begin
        for (int v = 0; v < vcr_arch_pkg::NumVc; v++) begin
          up_open[p][v] <= up_open[p][v] + int'(in_v_i[p] && in_data_i[p].hdr.vc == v)
                           - int'(up_credit_v_i[p] && up_credit_id_i[p] == v);
          ds_cred[p][v] <= ds_cred[p][v] + int'(ds_credit_v_i[p] && ds_credit_id_i[p] == v)
                           - int'(out_v_i[p] && out_data_i[p].hdr.vc == v);
        end
      end
    end
  end

  // ================================================
  // reset and per-port checks
  // ================================================
  a_quiet_start: assert property (@(posedge clk_i)
    (started && !seen_input) |-> (out_v_i == '0 && up_credit_v_i == '0))
    else begin
      $error("output or credit valid before the first flit");
      fail_count++;
    end

  for (genvar p = 0; p < vcr_arch_pkg::NumPorts; p++) begin : gen_port
    a_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_v_i[p] |-> out_data_i[p].hdr.dst == vcr_arch_pkg::port_e'(p))
      else begin
        $error("flit left on a port other than its destination");
        fail_count++;
      end
    for (genvar v = 0; v < vcr_arch_pkg::NumVc; v++) begin : gen_vc
      a_credit_matched: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (up_credit_v_i[p] && up_credit_id_i[p] == v) |-> up_open[p][v] > 0)
        else begin
          $error("credit returned without an accepted flit");
          fail_count++;
        end
      a_downstream_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_v_i[p] && out_data_i[p].hdr.vc == v) |-> ds_cred[p][v] > 0)
        else begin
          $error("flit sent downstream without a credit");
          fail_count++;
        end
    end
  end

endmodule

bind vcr_router vcr_assertions #(
  .VcDepth        (VcDepth)
) u_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .in_v_i         (data_v_i),
  .in_data_i      (data_i),
  .up_credit_v_i  (credit_v_o),
  .up_credit_id_i (credit_id_o),
  .ds_credit_v_i  (credit_v_i),
  .ds_credit_id_i (credit_id_i),
  .out_v_i        (data_v_o),
  .out_data_i     (data_o)
);

//--- tb/vcr_tb.sv
/*
  Testbench for the four-port VC router. Acts as credit-honouring upstream
  and downstream neighbours, keeps a scoreboard of expected flits and runs
  latency, random, back-pressure and fairness traffic against it.
*/

`timescale 1ns/1ps

module vcr_tb;

  localparam int VcDepth = 2;
  localparam int NumPorts = vcr_arch_pkg::NumPorts;
  localparam int NumVc = vcr_arch_pkg::NumVc;
  localparam int TotalFlits = 200;
  // per-flit budget covers the idle waits between latency flits
  localparam int TimeoutCycles = TotalFlits * 25;

  logic                                             clk;
  logic                                             rst_n;
  logic [NumPorts-1:0]                              data_v_in;
  vcr_flit_pkg::flit_t [NumPorts-1:0]               data_in;
  logic [NumPorts-1:0]                              credit_v_up;
  logic [NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] credit_id_up;
  logic [NumPorts-1:0]                              credit_v_ds;
  logic [NumPorts-1:0][vcr_arch_pkg::VcIdWidth-1:0] credit_id_ds;
  logic [NumPorts-1:0]                              data_v_out;
  vcr_flit_pkg::flit_t [NumPorts-1:0]               data_out;

  // expected flits per input, output and input vc
  vcr_flit_pkg::flit_t exp_q [NumPorts][NumPorts][NumVc][$];
  int                  due_q    [NumPorts][$];
  int                  due_vc_q [NumPorts][$];
  int                  up_cred  [NumPorts][NumVc];
  int                  ds_cred  [NumPorts][NumVc];
  int                  out_count [NumPorts];
  int                  south_hist [$];
  logic [NumPorts-1:0] hold_credit;
  logic                fair_mode;
  int                  cycle_now;
  int                  cycle_count;
  int                  in_flight;
  int                  errors;
  int                  seq;
  int                  last_out_cycle;
  int                  last_out_vc;
  logic [31:0]         lcg_state;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  vcr_router #(
    .VcDepth     (VcDepth)
  ) u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .data_v_i    (data_v_in),
    .data_i      (data_in),
    .credit_v_o  (credit_v_up),
    .credit_id_o (credit_id_up),
    .credit_v_i  (credit_v_ds),
    .credit_id_i (credit_id_ds),
    .data_v_o    (data_v_out),
    .data_o      (data_out)
  );

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // pick the output vc holding the most downstream credits
  // a tie goes to the lower index
  function automatic int best_vc(input int o);
    int b;
    b = 0;
    for (int v = 1; v < NumVc; v++) begin
      if (ds_cred[o][v] > ds_cred[o][b]) begin
        b = v;
      end
    end
    return b;
  endfunction

  function automatic logic is_idle();
    logic idle;
    idle = (in_flight == 0);
    for (int p = 0; p < NumPorts; p++) begin
      if (due_q[p].size() != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // ================================================
  // scoreboard and downstream neighbour
  // ================================================
  task automatic check_flit(input int o, input vcr_flit_pkg::flit_t f);
    int src;
    int hit;
    src = int'(f.hdr.src);
    hit = -1;
    for (int v = 0; v < NumVc; v++) begin
      if (hit < 0 && exp_q[src][o][v].size() > 0 &&
          exp_q[src][o][v][0].payload == f.payload) begin
        hit = v;
      end
    end
    assert (hit >= 0) else begin
      errors++;
      $display("Error at %0t: unexpected flit on port %0d, src %0d payload %h",
               $time, o, src, f.payload);
    end
    if (hit >= 0) begin
      void'(exp_q[src][o][hit].pop_front());
      in_flight--;
    end
    if (fair_mode && o == int'(vcr_arch_pkg::South)) begin
      foreach (south_hist[k]) begin
        assert (south_hist[k] != src) else begin
          errors++;
          $display("Error at %0t: source %0d repeats within four south flits", $time, src);
        end
      end
      south_hist.push_back(src);
      if (south_hist.size() > 3) begin
        void'(south_hist.pop_front());
      end
    end
    out_count[o]++;
    last_out_cycle = cycle_now;
    last_out_vc = int'(f.hdr.vc);
    ds_cred[o][f.hdr.vc]--;
    // credit goes back 1 to 4 cycles later
    due_q[o].push_back(cycle_now + 1 + int'(next_rand() % 4));
    due_vc_q[o].push_back(int'(f.hdr.vc));
  endtask

  // sample outputs at the falling edge and then drive the next inputs
  task automatic tick();
    @(negedge clk);
    cycle_now++;
    data_v_in = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (credit_v_up[p]) begin
        up_cred[p][credit_id_up[p]]++;
      end
      if (data_v_out[p]) begin
        check_flit(p, data_out[p]);
      end
      credit_v_ds[p] = 1'b0;
      if (!hold_credit[p] && due_q[p].size() > 0 && due_q[p][0] <= cycle_now) begin
        credit_v_ds[p]  = 1'b1;
        credit_id_ds[p] = vcr_arch_pkg::VcIdWidth'(due_vc_q[p].pop_front());
        void'(due_q[p].pop_front());
        ds_cred[p][credit_id_ds[p]]++;
      end
    end
  endtask

  // upstream neighbour sends only while it holds a credit
  task automatic send_flit(input int p, input int dst, output logic sent);
    int v;
    vcr_flit_pkg::flit_t f;
    v = int'(next_rand() % NumVc);
    if (up_cred[p][v] == 0) begin
      v = (v + 1) % NumVc;
    end
    sent = (up_cred[p][v] > 0);
    if (sent) begin
      f.hdr.vc  = vcr_arch_pkg::VcIdWidth'(v);
      f.hdr.dst = vcr_arch_pkg::port_e'(dst);
      f.hdr.src = vcr_arch_pkg::port_e'(p);
      f.payload = vcr_flit_pkg::PayloadWidth'(seq);
      seq++;
      up_cred[p][v]--;
      data_v_in[p] = 1'b1;
      data_in[p]   = f;
      exp_q[p][dst][v].push_back(f);
      in_flight++;
    end
  endtask

  task automatic wait_idle();
    do begin
      tick();
    end while (!is_idle());
  endtask

  // ================================================
  // tests
  // ================================================
  initial begin
    logic sent;
    int t0;
    int exp_vc;
    int target;
    int east_start;
    int per_in [NumPorts];
    rst_n        = 1'b0;
    data_v_in    = '0;
    data_in      = '0;
    credit_v_ds  = '0;
    credit_id_ds = '0;
    hold_credit  = '0;
    fair_mode    = 1'b0;
    cycle_now    = 0;
    in_flight    = 0;
    errors       = 0;
    seq          = 0;
    lcg_state    = 32'h88fa2a67;
    for (int p = 0; p < NumPorts; p++) begin
      out_count[p] = 0;
      per_in[p] = 0;
      for (int v = 0; v < NumVc; v++) begin
        up_cred[p][v] = VcDepth;
        ds_cred[p][v] = VcDepth;
      end
    end
    repeat (4) tick();
    rst_n = 1'b1;
    repeat (3) tick();

    // single flits into an idle router from every input to every output
    for (int p = 0; p < NumPorts; p++) begin
      for (int d = 0; d < NumPorts; d++) begin
        wait_idle();
        exp_vc = best_vc(d);
        send_flit(p, d, sent);
        t0 = cycle_now;
        while (in_flight != 0) begin
          tick();
        end
        assert (sent && last_out_cycle - t0 == 3 && last_out_vc == exp_vc) else begin
          errors++;
          $display("Error at %0t: flit %0d->%0d took %0d cycles on vc %0d, expected 3 on vc %0d",
                   $time, p, d, last_out_cycle - t0, last_out_vc, exp_vc);
        end
      end
    end
    wait_idle();

    // random traffic
    target = seq + 130;
    while (seq < target) begin
      tick();
      for (int p = 0; p < NumPorts; p++) begin
        if (seq < target && next_rand() % 4 != 0) begin
          send_flit(p, int'(next_rand() % NumPorts), sent);
        end
      end
    end
    wait_idle();

    // back-pressure on east
    hold_credit[vcr_arch_pkg::East] = 1'b1;
    east_start = out_count[vcr_arch_pkg::East];
    target = seq + 12;
    repeat (40) begin
      tick();
      for (int p = 0; p < NumPorts; p++) begin
        if (seq < target) begin
          send_flit(p, int'(vcr_arch_pkg::East), sent);
        end
      end
    end
    assert (out_count[vcr_arch_pkg::East] - east_start == NumVc * VcDepth) else begin
      errors++;
      $display("Error at %0t: %0d flits left east without credit return, expected %0d",
               $time, out_count[vcr_arch_pkg::East] - east_start, NumVc * VcDepth);
    end
    hold_credit = '0;
    wait_idle();

    // all inputs saturate south with an equal share each
    fair_mode = 1'b1;
    while (per_in[0] < 10 || per_in[1] < 10 || per_in[2] < 10 || per_in[3] < 10) begin
      tick();
      for (int p = 0; p < NumPorts; p++) begin
        if (per_in[p] < 10) begin
          send_flit(p, int'(vcr_arch_pkg::South), sent);
          per_in[p] += int'(sent);
        end
      end
    end
    wait_idle();
    fair_mode = 1'b0;

    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        assert (up_cred[p][v] == VcDepth) else begin
          errors++;
          $display("Error at %0t: input %0d vc %0d holds %0d credits, expected %0d",
                   $time, p, v, up_cred[p][v], VcDepth);
        end
      end
    end
    $display("summary: %0d flits, %0d scoreboard errors, %0d assertion failures",
             seq, errors, u_dut.u_assertions.fail_count);
    if (errors == 0 && u_dut.u_assertions.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit in clock cycles
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: traffic did not drain within %0d cycles", TimeoutCycles);
    $display("test failed");
    $finish;
  end

endmodule

//--- sources.f
rtl/vcr_arch_pkg.sv
rtl/vcr_flit_pkg.sv
rtl/vcr_req_if.sv
rtl/vcr_input_port.sv
rtl/vcr_switch_alloc.sv
rtl/vcr_output_credits.sv
rtl/vcr_switch_traversal.sv
rtl/vcr_router.sv
tb/vcr_assertions.sv
tb/vcr_tb.sv

//--- Bender.yml
package:
  name: vcr_router

sources:
  - rtl/vcr_arch_pkg.sv
  - rtl/vcr_flit_pkg.sv
  - rtl/vcr_req_if.sv
  - rtl/vcr_input_port.sv
  - rtl/vcr_switch_alloc.sv
  - rtl/vcr_output_credits.sv
  - rtl/vcr_switch_traversal.sv
  - rtl/vcr_router.sv
  - target: simulation
    files:
      - tb/vcr_assertions.sv
      - tb/vcr_tb.sv
